// File: Bender.yml
package:
  name: sha_miner

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/sha_miner_pkg.sv
      - source/sha_round_stage.sv
      - source/sha_nonce_counter.sv
      - source/sha_pre_pipeline.sv
      - source/sha_sched_stage.sv
      - source/sha_main_pipeline.sv
      - source/sha_finalize.sv
      - source/sha_miner_top.sv
  - target: test
    files:
      - test/sha_miner_assert.sv
      - test/sha_miner_tb.sv

// File: source/sha_finalize.sv
`timescale 1ns/1ps
`include "sha_miner_cfg.svh"

module sha_finalize (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,
  input  sha_miner_pkg::hash_state_t state_i,
  input  sha_miner_pkg::hash_state_t midstate_i,
  output logic                       valid_o,
  output sha_miner_pkg::hash_state_t digest_o,
  output sha_miner_pkg::nonce_t      nonce_o
);

  localparam int unsigned DEPTH = `SHA_ROUNDS;  // Cycles from acceptance to this stage's input

  sha_miner_pkg::hash_state_t mid_line [0:DEPTH-1];  // Midstate of each candidate in flight

  always_ff @(posedge clk_i) begin
    mid_line[0] <= midstate_i;
    for (int n = 1; n < DEPTH; n++) begin
      mid_line[n] <= mid_line[n-1];  // Last tap meets the round state of the same candidate
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 8; i++) begin
      digest_o[i*32 +: 32] <= mid_line[DEPTH-1][i*32 +: 32] + state_i[i*32 +: 32];  // Mod 2^32
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;  // Digest and valid leave in the same cycle
    end
  end

  // Regenerated nonce, one cycle behind its inputs like the digest
  sha_nonce_counter u_nonce_out (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (valid_i & newblock_i),
    .inc_i   (valid_i),
    .count_o (nonce_o)
  );

endmodule

// File: source/sha_main_pipeline.sv
`timescale 1ns/1ps
`include "sha_miner_cfg.svh"

module sha_main_pipeline (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,
  input  sha_miner_pkg::hash_state_t state_i,
  input  sha_miner_pkg::history_t    history_i,
  output logic                       valid_o,
  output logic                       newblock_o,
  output sha_miner_pkg::hash_state_t state_o
);

  localparam int unsigned STAGES = `SHA_ROUNDS - `SHA_PRE_ROUNDS;  // Rounds 15 to 63

  logic                       valid_pipe    [0:STAGES];
  logic                       newblock_pipe [0:STAGES];
  sha_miner_pkg::hash_state_t state_pipe    [0:STAGES];
  sha_miner_pkg::history_t    history_pipe  [0:STAGES];  // Last entry has no consumer

  assign valid_pipe[0]    = valid_i;
  assign newblock_pipe[0] = newblock_i;
  assign state_pipe[0]    = state_i;
  assign history_pipe[0]  = history_i;

  assign valid_o    = valid_pipe[STAGES];
  assign newblock_o = newblock_pipe[STAGES];
  assign state_o    = state_pipe[STAGES];

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    sha_sched_stage #(
      .K (sha_miner_pkg::sha_k(`SHA_PRE_ROUNDS + i))  // Round index continues from the pre-pipeline
    ) u_sched (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .valid_i    (valid_pipe[i]),
      .newblock_i (newblock_pipe[i]),
      .state_i    (state_pipe[i]),
      .history_i  (history_pipe[i]),
      .valid_o    (valid_pipe[i+1]),
      .newblock_o (newblock_pipe[i+1]),
      .state_o    (state_pipe[i+1]),
      .history_o  (history_pipe[i+1])
    );
  end

endmodule

// File: source/sha_miner_cfg.svh
`ifndef SHA_MINER_CFG_SVH
`define SHA_MINER_CFG_SVH

// Rounds 0 to 14 see message words that are known before the schedule starts
`define SHA_PRE_ROUNDS 15

`define SHA_ROUNDS 64  // Full SHA-256 compression

// The single one bit that follows the 16 header bytes of the second block
`define SHA_PAD_WORD 32'h8000_0000

`define SHA_MSG_BITS 640  // The 80-byte header length, in the last schedule word

`endif

// File: source/sha_miner_pkg.sv
package sha_miner_pkg;

  typedef logic [31:0]  word_t;        // One SHA-256 word
  typedef logic [255:0] hash_state_t;  // Working variables a to h with a in the top word
  typedef logic [31:0]  nonce_t;       // Header nonce as hashed
  typedef logic [511:0] history_t;     // Schedule window with word 15 the oldest

  // FIPS 180-4 round constants
  localparam word_t K_TABLE [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Round constant lookup, also usable in parameter overrides
  function automatic word_t sha_k(input int unsigned idx);
    return K_TABLE[idx];
  endfunction

  // Right rotation used by all four sigma functions
  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

endpackage

// File: source/sha_miner_top.sv
`timescale 1ns/1ps

module sha_miner_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,  // First candidate of a new header
  input  sha_miner_pkg::hash_state_t midstate_i,
  input  sha_miner_pkg::word_t       merkle_tail_i,
  input  sha_miner_pkg::word_t       timestamp_i,
  input  sha_miner_pkg::word_t       target_i,
  output logic                       valid_o,
  output sha_miner_pkg::hash_state_t digest_o,
  output sha_miner_pkg::nonce_t      nonce_o
);

  logic                       pre_valid, pre_newblock;
  sha_miner_pkg::hash_state_t pre_state;
  sha_miner_pkg::history_t    pre_history;   // Full W0 to W15 window
  logic                       main_valid, main_newblock;
  sha_miner_pkg::hash_state_t main_state;    // State after round 63

  sha_pre_pipeline u_pre (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .newblock_i (newblock_i),
    .state_i    (midstate_i),  // Compression starts from the midstate
    .w1_i       (merkle_tail_i),
    .w2_i       (timestamp_i),
    .w3_i       (target_i),
    .valid_o    (pre_valid),
    .newblock_o (pre_newblock),
    .state_o    (pre_state),
    .history_o  (pre_history)
  );

  sha_main_pipeline u_main (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (pre_valid),
    .newblock_i (pre_newblock),
    .state_i    (pre_state),
    .history_i  (pre_history),
    .valid_o    (main_valid),
    .newblock_o (main_newblock),
    .state_o    (main_state)
  );

  sha_finalize u_final (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (main_valid),
    .newblock_i (main_newblock),
    .state_i    (main_state),
    .midstate_i (midstate_i),  // Delayed inside to meet its own candidate
    .valid_o    (valid_o),
    .digest_o   (digest_o),
    .nonce_o    (nonce_o)
  );

endmodule

// File: source/sha_nonce_counter.sv
`timescale 1ns/1ps

module sha_nonce_counter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  clear_i,
  input  logic                  inc_i,
  output sha_miner_pkg::nonce_t count_o
);

  // The count registered from the upstream lane is the nonce of the candidate that
  // has just moved one stage further, so a newblock candidate must leave behind 0
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (clear_i) begin
      count_o <= '0;                  // First candidate of a header hashes nonce 0
    end else if (inc_i) begin
      count_o <= count_o + 32'd1;     // Each later candidate takes the next nonce
    end
  end

endmodule

// File: source/sha_pre_pipeline.sv
`timescale 1ns/1ps
`include "sha_miner_cfg.svh"

module sha_pre_pipeline (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,
  input  sha_miner_pkg::hash_state_t state_i,
  input  sha_miner_pkg::word_t       w1_i,  // Last word of the merkle root
  input  sha_miner_pkg::word_t       w2_i,  // Timestamp
  input  sha_miner_pkg::word_t       w3_i,  // Difficulty target
  output logic                       valid_o,
  output logic                       newblock_o,
  output sha_miner_pkg::hash_state_t state_o,
  output sha_miner_pkg::history_t    history_o
);

  localparam int unsigned N = `SHA_PRE_ROUNDS;

  logic                       valid_pipe    [0:N];
  logic                       newblock_pipe [0:N];
  sha_miner_pkg::hash_state_t state_pipe    [0:N];
  logic [95:0]                word_pipe     [0:N];  // Header words travelling with each candidate
  sha_miner_pkg::word_t       m             [0:N-1];
  sha_miner_pkg::nonce_t      nonce_round;
  sha_miner_pkg::nonce_t      nonce_exit;

  assign valid_pipe[0]    = valid_i;
  assign newblock_pipe[0] = newblock_i;
  assign state_pipe[0]    = state_i;
  assign word_pipe[0]     = {w1_i, w2_i, w3_i};

  assign valid_o    = valid_pipe[N];
  assign newblock_o = newblock_pipe[N];
  assign state_o    = state_pipe[N];

  assign m[0] = word_pipe[0][95:64];  // Each round reads the words of its own candidate
  assign m[1] = word_pipe[1][63:32];
  assign m[2] = word_pipe[2][31:0];
  assign m[3] = nonce_round;
  assign m[4] = `SHA_PAD_WORD;

  // Padding is zero up to the length word
  for (genvar n = 5; n < N; n++) begin : g_zero
    assign m[n] = '0;
  end

  // Counters lag by one cycle, so they watch the lane one stage upstream
  sha_nonce_counter u_nonce_round (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (valid_pipe[2] & newblock_pipe[2]),
    .inc_i   (valid_pipe[2]),
    .count_o (nonce_round)
  );

  sha_nonce_counter u_nonce_exit (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (valid_pipe[N-1] & newblock_pipe[N-1]),
    .inc_i   (valid_pipe[N-1]),
    .count_o (nonce_exit)
  );

  for (genvar n = 0; n < N; n++) begin : g_round
    sha_round_stage #(
      .K (sha_miner_pkg::sha_k(n))
    ) u_round (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .valid_i    (valid_pipe[n]),
      .newblock_i (newblock_pipe[n]),
      .state_i    (state_pipe[n]),
      .w_i        (m[n]),
      .valid_o    (valid_pipe[n+1]),
      .newblock_o (newblock_pipe[n+1]),
      .state_o    (state_pipe[n+1])
    );

    always_ff @(posedge clk_i) begin
      word_pipe[n+1] <= word_pipe[n];  // Keeps the words aligned when the header changes
    end
  end

  // Window words 15 down to 0 are W0 to W15 of this candidate
  assign history_o = {word_pipe[N], nonce_exit, `SHA_PAD_WORD,
                      {(N - 5){32'h0}}, 32'(`SHA_MSG_BITS)};

endmodule

// File: source/sha_round_stage.sv
`timescale 1ns/1ps

module sha_round_stage #(
  parameter sha_miner_pkg::word_t K = '0  // Round constant of this stage
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,
  input  sha_miner_pkg::hash_state_t state_i,
  input  sha_miner_pkg::word_t       w_i,
  output logic                       valid_o,
  output logic                       newblock_o,
  output sha_miner_pkg::hash_state_t state_o
);

  sha_miner_pkg::word_t a, b, c, d, e, f, g, h;
  sha_miner_pkg::word_t big_sigma0, big_sigma1;
  sha_miner_pkg::word_t ch, maj, t1, t2;

  assign {a, b, c, d, e, f, g, h} = state_i;  // Unpack with a taken from the top word

  assign big_sigma0 = sha_miner_pkg::rotr(a, 2) ^ sha_miner_pkg::rotr(a, 13) ^
                      sha_miner_pkg::rotr(a, 22);
  assign big_sigma1 = sha_miner_pkg::rotr(e, 6) ^ sha_miner_pkg::rotr(e, 11) ^
                      sha_miner_pkg::rotr(e, 25);

  assign ch  = (e & f) ^ (~e & g);            // Choose f or g by the bits of e
  assign maj = (a & b) ^ (a & c) ^ (b & c);   // Bitwise majority of a, b and c

  assign t1 = h + big_sigma1 + ch + K + w_i;  // Depends on the message word
  assign t2 = big_sigma0 + maj;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;  // Pipeline empties on reset
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    newblock_o <= newblock_i;                                // Flag follows its candidate
    state_o    <= {t1 + t2, a, b, c, d + t1, e, f, g};       // Variables shift down by one
  end

endmodule

// File: source/sha_sched_stage.sv
`timescale 1ns/1ps

module sha_sched_stage #(
  parameter sha_miner_pkg::word_t K = '0  // Round constant passed to the round
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  logic                       newblock_i,
  input  sha_miner_pkg::hash_state_t state_i,
  input  sha_miner_pkg::history_t    history_i,
  output logic                       valid_o,
  output logic                       newblock_o,
  output sha_miner_pkg::hash_state_t state_o,
  output sha_miner_pkg::history_t    history_o
);

  sha_miner_pkg::word_t w_now;    // W[t] for this round
  sha_miner_pkg::word_t w_back1;  // W[t-1]
  sha_miner_pkg::word_t w_back6;  // W[t-6]
  sha_miner_pkg::word_t w_back14; // W[t-14]
  sha_miner_pkg::word_t w_back15; // W[t-15]
  sha_miner_pkg::word_t small_sigma0, small_sigma1, w_next;

  assign w_now    = history_i[31:0];
  assign w_back1  = history_i[1*32 +: 32];
  assign w_back6  = history_i[6*32 +: 32];
  assign w_back14 = history_i[14*32 +: 32];
  assign w_back15 = history_i[15*32 +: 32];

  assign small_sigma0 = sha_miner_pkg::rotr(w_back14, 7) ^ sha_miner_pkg::rotr(w_back14, 18) ^
                        (w_back14 >> 3);
  assign small_sigma1 = sha_miner_pkg::rotr(w_back1, 17) ^ sha_miner_pkg::rotr(w_back1, 19) ^
                        (w_back1 >> 10);

  assign w_next = small_sigma1 + w_back6 + small_sigma0 + w_back15;  // W[t+1]

  sha_round_stage #(
    .K (K)
  ) u_round (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .newblock_i (newblock_i),
    .state_i    (state_i),
    .w_i        (w_now),
    .valid_o    (valid_o),
    .newblock_o (newblock_o),
    .state_o    (state_o)
  );

  always_ff @(posedge clk_i) begin
    history_o <= {history_i[479:0], w_next};  // Oldest word drops out at the top
  end

endmodule

// File: tb.f
+incdir+source
source/sha_miner_pkg.sv
source/sha_round_stage.sv
source/sha_nonce_counter.sv
source/sha_pre_pipeline.sv
source/sha_sched_stage.sv
source/sha_main_pipeline.sv
source/sha_finalize.sv
source/sha_miner_top.sv
test/sha_miner_assert.sv
test/sha_miner_tb.sv

// File: test/sha_miner_assert.sv
`timescale 1ns/1ps

module sha_miner_assert (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  valid_i,         // Candidate accepted at the top
  input logic                  out_valid_i,     // Digest leaving the core
  input sha_miner_pkg::nonce_t out_nonce_i,
  input logic                  fin_newblock_i   // Newblock flag entering the finalizer
);

  int unsigned fail_count = 0;  // Read by the testbench for its closing count

  a_reset_quiet : assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else begin
      $error("valid_o is high while reset is asserted");
      fail_count++;
    end

  // 15 pre rounds, 49 schedule rounds and the final addition
  a_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> ##65 out_valid_i)
    else begin
      $error("valid_o did not follow valid_i after 65 cycles");
      fail_count++;
    end

  a_no_spurious : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> $past(valid_i, 65))
    else begin
      $error("valid_o rose without a candidate accepted 65 cycles earlier");
      fail_count++;
    end

  // The flag at the finalizer input belongs to the digest one cycle later
  a_nonce_step : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && $past(out_valid_i) && !$past(fin_newblock_i) |->
    out_nonce_i == $past(out_nonce_i) + 32'd1)
    else begin
      $error("nonce_o did not advance by one between back-to-back outputs");
      fail_count++;
    end

endmodule

bind sha_miner_top sha_miner_assert u_assert (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .valid_i        (valid_i),
  .out_valid_i    (valid_o),
  .out_nonce_i    (nonce_o),
  .fin_newblock_i (main_newblock)
);

// File: test/sha_miner_tb.sv
`timescale 1ns/1ps

module sha_miner_tb;

  typedef struct {
    string                      name;
    logic                       valid;
    logic                       newblock;
    sha_miner_pkg::hash_state_t mid;
    sha_miner_pkg::word_t       merkle, stamp, target;
    sha_miner_pkg::hash_state_t exp_digest;  // Model result for valid rows
    sha_miner_pkg::nonce_t      exp_nonce;
    int                         in_cyc;      // Cycle count when the row was driven
  } row_t;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       valid_in, newblock;
  sha_miner_pkg::hash_state_t midstate;
  sha_miner_pkg::word_t       merkle_tail, timestamp, target;
  logic                       valid_out;
  sha_miner_pkg::hash_state_t digest;
  sha_miner_pkg::nonce_t      nonce;

  sha_miner_pkg::word_t       k_tab [0:63];
  sha_miner_pkg::hash_state_t hdr_mid [0:3];       // One midstate per header
  sha_miner_pkg::word_t       hdr_word [0:3][0:2]; // Merkle tail, timestamp and target
  sha_miner_pkg::nonce_t      nonce_model;
  row_t                       stim_q [$];
  row_t                       exp_q [$];           // Scoreboard in output order
  integer                     seed = 3;
  int                         cyc = 0;
  int                         mismatches = 0;
  int                         failures = 0;

  sha_miner_top dut_i (
    .clk_i (clk), .rst_n_i (rst_n), .valid_i (valid_in), .newblock_i (newblock),
    .midstate_i (midstate), .merkle_tail_i (merkle_tail), .timestamp_i (timestamp),
    .target_i (target), .valid_o (valid_out), .digest_o (digest), .nonce_o (nonce)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) cyc <= cyc + 1;

  function automatic sha_miner_pkg::word_t rotate_right(sha_miner_pkg::word_t x, int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // K is the first 32 fraction bits of the cube roots of the first 64 primes
  task automatic derive_round_constants();
    int  p;
    int  found;
    bit  prime;
    real root;
    p = 1;
    found = 0;
    while (found < 64) begin
      p++;
      prime = 1'b1;
      for (int d = 2; d * d <= p; d++) begin
        if (p % d == 0) prime = 1'b0;
      end
      if (prime) begin
        root = $pow(p, 1.0 / 3.0);
        k_tab[found] = 32'(longint'($floor((root - $floor(root)) * 4294967296.0)));
        found++;
      end
    end
  endtask

  // Second block compression of the 80-byte header
  function automatic sha_miner_pkg::hash_state_t compress(sha_miner_pkg::hash_state_t mid,
      sha_miner_pkg::word_t w0, sha_miner_pkg::word_t w1, sha_miner_pkg::word_t w2,
      sha_miner_pkg::word_t w3);
    sha_miner_pkg::word_t w [0:63];
    sha_miner_pkg::word_t a, b, c, d, e, f, g, h;
    sha_miner_pkg::word_t s0, s1, t1, t2;
    w[0] = w0;
    w[1] = w1;
    w[2] = w2;
    w[3] = w3;                   // Nonce word
    w[4] = 32'h8000_0000;        // Single padding one bit
    for (int t = 5; t < 15; t++) w[t] = '0;
    w[15] = 32'd640;             // Header length in bits
    for (int t = 16; t < 64; t++) begin
      s0 = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
    end
    {a, b, c, d, e, f, g, h} = mid;
    for (int t = 0; t < 64; t++) begin
      t1 = h + (rotate_right(e, 6) ^ rotate_right(e, 11) ^ rotate_right(e, 25)) +
           ((e & f) ^ (~e & g)) + k_tab[t] + w[t];
      t2 = (rotate_right(a, 2) ^ rotate_right(a, 13) ^ rotate_right(a, 22)) +
           ((a & b) ^ (a & c) ^ (b & c));
      {h, g, f, e, d, c, b, a} = {g, f, e, d + t1, c, b, a, t1 + t2};
    end
    return {a + mid[255:224], b + mid[223:192], c + mid[191:160], d + mid[159:128],
            e + mid[127:96], f + mid[95:64], g + mid[63:32], h + mid[31:0]};
  endfunction

  // Appends one cycle of stimulus with its expected result from the nonce rule
  task automatic add_row(string name, int hdr, logic valid, logic nb);
    row_t row;
    row.name     = name;
    row.valid    = valid;
    row.newblock = nb & valid;
    row.mid      = hdr_mid[hdr];
    row.merkle   = hdr_word[hdr][0];
    row.stamp    = hdr_word[hdr][1];
    row.target   = hdr_word[hdr][2];
    if (valid) nonce_model = row.newblock ? '0 : nonce_model + 32'd1;  // Idle rows hold
    row.exp_nonce  = nonce_model;
    row.exp_digest = compress(row.mid, row.merkle, row.stamp, row.target, nonce_model);
    stim_q.push_back(row);
  endtask

  task automatic build_table();
    for (int h = 0; h < 4; h++) begin
      for (int j = 0; j < 8; j++) hdr_mid[h][j*32 +: 32] = $random(seed);
      for (int j = 0; j < 3; j++) hdr_word[h][j] = $random(seed);
    end
    add_row("single", 0, 1'b1, 1'b1);
    repeat (3) add_row("single_gap", 0, 1'b0, 1'b0);
    add_row("burst", 1, 1'b1, 1'b1);
    repeat (5) add_row("burst", 1, 1'b1, 1'b0);
    add_row("idle", 1, 1'b0, 1'b0);
    add_row("idle", 1, 1'b1, 1'b0);   // Nonce continues after the gap
    repeat (2) add_row("idle", 1, 1'b0, 1'b0);
    add_row("idle", 1, 1'b1, 1'b0);
    add_row("overlap_old", 2, 1'b1, 1'b1);
    repeat (3) add_row("overlap_old", 2, 1'b1, 1'b0);
    add_row("overlap_new", 3, 1'b1, 1'b1);  // Old header still in flight
    repeat (3) add_row("overlap_new", 3, 1'b1, 1'b0);
  endtask

  always @(negedge clk) begin : monitor
    row_t got;
    if (valid_out === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        $display("output appeared at cycle %0d with no candidate in flight", cyc);
        failures++;
      end
      if (exp_q.size() != 0) begin
        got = exp_q.pop_front();
        assert (digest === got.exp_digest) else begin
          $display("mismatch %s digest expected %h actual %h", got.name, got.exp_digest, digest);
          mismatches++;
        end
        assert (nonce === got.exp_nonce) else begin
          $display("mismatch %s nonce expected %0d actual %0d", got.name, got.exp_nonce, nonce);
          mismatches++;
        end
        assert (cyc - got.in_cyc == 65) else begin
          $display("mismatch %s latency expected 65 actual %0d", got.name, cyc - got.in_cyc);
          mismatches++;
        end
      end
    end
  end

  initial begin : stimulus
    int wait_cyc;
    int total;
    valid_in    = 1'b0;
    newblock    = 1'b0;
    midstate    = '0;
    merkle_tail = '0;
    timestamp   = '0;
    target      = '0;
    rst_n       = 1'b1;
    nonce_model = '0;
    derive_round_constants();
    build_table();
    #1 rst_n = 1'b0;           // Falling edge clears the valid lanes before the first clock
    repeat (16) @(posedge clk);
    #0.5 rst_n = 1'b1;
    repeat (8) @(posedge clk); // Output must stay quiet with nothing accepted
    foreach (stim_q[r]) begin
      @(posedge clk);
      #0.5;
      valid_in    = stim_q[r].valid;
      newblock    = stim_q[r].newblock;
      midstate    = stim_q[r].mid;
      merkle_tail = stim_q[r].merkle;
      timestamp   = stim_q[r].stamp;
      target      = stim_q[r].target;
      stim_q[r].in_cyc = cyc;
      if (stim_q[r].valid) exp_q.push_back(stim_q[r]);
    end
    @(posedge clk);
    #0.5;
    valid_in = 1'b0;
    newblock = 1'b0;
    wait_cyc = 0;
    while (exp_q.size() != 0 && wait_cyc < 200) begin
      @(posedge clk);
      wait_cyc++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timeout waiting for outputs, %0d candidates never emerged", exp_q.size());
      failures++;
    end
    repeat (8) @(posedge clk); // Catches stray outputs after the last candidate
    total = mismatches + failures + int'(dut_i.u_assert.fail_count);
    $display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut_i.u_assert.fail_count);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
